// File: Makefile
TOP = tb_soc

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f soc_periph.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: common/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // top five address bits pick the region
    typedef enum logic [4:0] {
        REGION_ROM         = 5'd0,
        REGION_RAM         = 5'd1,
        REGION_UART_DATA   = 5'd29,
        REGION_UART_STATUS = 5'd30,
        REGION_PORTS       = 5'd31
    } region_t;

    // one bus address, seen raw or split into region and byte offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            region_t     region;
            logic [26:0] offset;
        } f;
    } bus_addr_u;

    // word address widths
    localparam int ROM_BITS = 4;
    localparam int RAM_BITS = 8;

    // cpu_clk cycles per serial bit
    localparam int UART_CLOCK_DIV = 8;
    localparam int UART_DIV_BITS = $clog2(UART_CLOCK_DIV);
    localparam int UART_FIFO_DEPTH = 4;
    localparam int UART_PTR_BITS = $clog2(UART_FIFO_DEPTH);

    // interrupt every 1024 cycles
    localparam int TIMER_BITS = 10;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: logic/io_ports.sv
`timescale 1ns/1ns
`default_nettype none

module io_ports import soc_pkg::*; (
    input  logic        cpu_clk,
    input  logic        reset,
    input  logic        led_wr,
    input  logic [31:0] wr_data,
    input  logic        irq_clear,
    input  logic        port_sel,
    input  logic [4:0]  buttons,
    output logic        led,
    output logic        timer_irq,
    output logic [31:0] port_rdata
);
    logic [TIMER_BITS-1:0] timer;

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            timer <= '0;
            led <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            timer <= timer + 1'b1;
            if (led_wr) begin
                led <= wr_data[0];
            end
            // a wrap in the same cycle beats the clear
            if (&timer) begin
                timer_irq <= 1'b1;
            end else if (irq_clear) begin
                timer_irq <= 1'b0;
            end
        end
    end

    // buttons taken as they are at read time
    always_ff @(posedge cpu_clk) begin
        if (port_sel) begin
            port_rdata <= {23'h000000, timer_irq, 1'b0, buttons, 1'b0, led};
        end
    end

endmodule

`default_nettype wire

// File: logic/periph_bus.sv
`timescale 1ns/1ns
`default_nettype none

module periph_bus import soc_pkg::*; (
    input  logic                cpu_clk,
    input  logic                reset,
    input  logic [31:0]         awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [31:0]         araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    output logic [RAM_BITS-1:0] word_addr,
    output logic                rom_sel,
    output logic                ram_sel,
    output logic [3:0]          ram_strb,
    output logic [31:0]         wr_data,
    output logic                uart_push,
    output logic                uart_pop,
    output logic                port_sel,
    output logic                led_wr,
    output logic                irq_clear,
    input  logic [31:0]         rom_rdata,
    input  logic [31:0]         ram_rdata,
    input  logic [7:0]          uart_rdata,
    input  logic                uart_full,
    input  logic                uart_empty,
    input  logic [31:0]         port_rdata
);
    bus_addr_u  req_addr;
    region_t    region;
    region_t    rd_region;
    logic       ready_q;
    logic       idle;
    logic       wr_hs;
    logic       rd_hs;
    logic       wr_ok;
    logic       rd_ok;
    logic [1:0] status_q;

    // one transaction in flight at a time
    assign idle = ready_q && !bvalid && !rvalid;
    assign awready = idle;
    assign wready = idle;
    // write wins when both channels arrive together
    assign arready = idle && !(awvalid && wvalid);
    assign wr_hs = awvalid && wvalid && idle;
    assign rd_hs = arvalid && arready;

    assign req_addr.raw = wr_hs ? awaddr : araddr;
    assign region = req_addr.f.region;
    assign word_addr = req_addr.raw[RAM_BITS+1:2];
    assign wr_data = wdata;

    always_comb begin
        wr_ok = 1'b0;
        rd_ok = 1'b1;
        case (region)
            REGION_RAM, REGION_PORTS: wr_ok = 1'b1;
            REGION_UART_DATA:         wr_ok = !uart_full;
            REGION_ROM, REGION_UART_STATUS: wr_ok = 1'b0;
            default:                  rd_ok = 1'b0;
        endcase
    end

    assign rom_sel = rd_hs && region == REGION_ROM;
    assign ram_sel = (wr_hs || rd_hs) && region == REGION_RAM;
    assign ram_strb = (wr_hs && region == REGION_RAM) ? wstrb : 4'b0000;
    assign uart_push = wr_hs && region == REGION_UART_DATA && !uart_full;
    assign uart_pop = rd_hs && region == REGION_UART_DATA;
    assign port_sel = rd_hs && region == REGION_PORTS;
    assign led_wr = wr_hs && region == REGION_PORTS && wstrb[0];
    assign irq_clear = wr_hs && region == REGION_PORTS && wstrb[1] && wdata[8];

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            ready_q <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            bresp <= RESP_OKAY;
            rresp <= RESP_OKAY;
        end else begin
            ready_q <= 1'b1;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // flags are live, so status is captured at the handshake
    always_ff @(posedge cpu_clk) begin
        if (rd_hs) begin
            rd_region <= region;
            status_q <= {uart_empty, uart_full};
        end
    end

    always_comb begin
        case (rd_region)
            REGION_ROM:         rdata = rom_rdata;
            REGION_RAM:         rdata = ram_rdata;
            REGION_UART_DATA:   rdata = {24'h000000, uart_rdata};
            REGION_UART_STATUS: rdata = {30'h00000000, status_q};
            REGION_PORTS:       rdata = port_rdata;
            default:            rdata = 32'h00000000;
        endcase
    end

    a_one_resp: assert property (@(posedge cpu_clk) disable iff (!reset)
        !(bvalid && rvalid));

    // block read registers must not move under a stalled response
    a_rdata_hold: assert property (@(posedge cpu_clk) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: logic/soc_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_periph_top import soc_pkg::*; (
    input  wire         cpu_clk,
    input  wire         reset,
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    output wire         awready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wvalid,
    output wire         wready,
    output wire  [1:0]  bresp,
    output wire         bvalid,
    input  wire         bready,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    output wire         arready,
    output wire  [31:0] rdata,
    output wire  [1:0]  rresp,
    output wire         rvalid,
    input  wire         rready,
    output wire         tx,
    input  wire         rx,
    input  wire  [4:0]  buttons,
    output wire         led,
    output wire         timer_irq
);
    wire [RAM_BITS-1:0] word_addr;
    wire                rom_sel;
    wire                ram_sel;
    wire [3:0]          ram_strb;
    wire [31:0]         wr_data;
    wire                uart_push;
    wire                uart_pop;
    wire                port_sel;
    wire                led_wr;
    wire                irq_clear;
    wire [31:0]         rom_rdata;
    wire [31:0]         ram_rdata;
    wire [7:0]          uart_rdata;
    wire                uart_full;
    wire                uart_empty;
    wire [31:0]         port_rdata;

    periph_bus bus_i (
        .cpu_clk(cpu_clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .word_addr(word_addr), .rom_sel(rom_sel), .ram_sel(ram_sel),
        .ram_strb(ram_strb), .wr_data(wr_data), .uart_push(uart_push),
        .uart_pop(uart_pop), .port_sel(port_sel), .led_wr(led_wr),
        .irq_clear(irq_clear), .rom_rdata(rom_rdata), .ram_rdata(ram_rdata),
        .uart_rdata(uart_rdata), .uart_full(uart_full), .uart_empty(uart_empty),
        .port_rdata(port_rdata)
    );

    code_rom rom_i (
        .cpu_clk(cpu_clk), .rom_sel(rom_sel),
        .word_addr(word_addr[ROM_BITS-1:0]), .rom_rdata(rom_rdata)
    );

    data_ram ram_i (
        .cpu_clk(cpu_clk), .ram_sel(ram_sel), .word_addr(word_addr),
        .ram_strb(ram_strb), .wr_data(wr_data), .ram_rdata(ram_rdata)
    );

    uart_fifo uart_i (
        .cpu_clk(cpu_clk), .reset(reset), .uart_push(uart_push),
        .wr_data(wr_data[7:0]), .uart_pop(uart_pop), .rx(rx), .tx(tx),
        .uart_rdata(uart_rdata), .uart_full(uart_full), .uart_empty(uart_empty)
    );

    io_ports ports_i (
        .cpu_clk(cpu_clk), .reset(reset), .led_wr(led_wr), .wr_data(wr_data),
        .irq_clear(irq_clear), .port_sel(port_sel), .buttons(buttons),
        .led(led), .timer_irq(timer_irq), .port_rdata(port_rdata)
    );

endmodule

`default_nettype wire

// File: memory/code_rom.sv
`timescale 1ns/1ns
`default_nettype none

module code_rom import soc_pkg::*; (
    input  logic                cpu_clk,
    input  logic                rom_sel,
    input  logic [ROM_BITS-1:0] word_addr,
    output logic [31:0]         rom_rdata
);
    logic [31:0] rom [0:(1 << ROM_BITS) - 1];

    initial begin
        $readmemh("rom_init.hex", rom);
    end

    always_ff @(posedge cpu_clk) begin
        if (rom_sel) begin
            rom_rdata <= rom[word_addr];
        end
    end

endmodule

`default_nettype wire

// File: memory/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram import soc_pkg::*; (
    input  logic                cpu_clk,
    input  logic                ram_sel,
    input  logic [RAM_BITS-1:0] word_addr,
    input  logic [3:0]          ram_strb,
    input  logic [31:0]         wr_data,
    output wire  [31:0]         ram_rdata
);

    // one byte-wide array per lane
    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [7:0] mem [0:(1 << RAM_BITS) - 1];
        logic [7:0] rd_q;

        always_ff @(posedge cpu_clk) begin
            if (ram_sel) begin
                if (ram_strb[i]) begin
                    mem[word_addr] <= wr_data[8*i +: 8];
                end
                rd_q <= mem[word_addr];
            end
        end

        assign ram_rdata[8*i +: 8] = rd_q;
    end

endmodule

`default_nettype wire

// File: rom_init.hex
// one 32-bit ROM word per line, word address 0 first
00000297
0a028293
00100313
0062a023
fff30313
fe031ee3
12345678
9abcdef0
deadbeef
0badf00d
c001d00d
00ff00ff
a5a5a5a5
5a5a5a5a
80000001
7ffffffe

// File: soc_periph.f
common/soc_pkg.sv
memory/code_rom.sv
memory/data_ram.sv
uart/uart_fifo.sv
logic/io_ports.sv
logic/periph_bus.sv
logic/soc_periph_top.sv
tb/tb_soc.sv

// File: tb/tb_soc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc import soc_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int IRQ_PERIOD = 1 << TIMER_BITS;
    localparam int FRAME_CYCLES = 10 * UART_CLOCK_DIV;
    localparam int NUM_TRANS = 700;
    localparam int WATCHDOG_CYCLES = 2000 * NUM_TRANS + 20 * FRAME_CYCLES;
    localparam logic [31:0] ROM_BASE = 32'h0000_0000;
    localparam logic [31:0] RAM_BASE = 32'h0800_0000;
    localparam logic [31:0] UART_DATA = 32'hE800_0000;
    localparam logic [31:0] UART_STATUS = 32'hF000_0000;
    localparam logic [31:0] PORTS = 32'hF800_0000;

    logic        cpu_clk;
    logic        reset;
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
    logic [4:0]  buttons;
    wire         awready;
    wire         wready;
    wire  [1:0]  bresp;
    wire         bvalid;
    wire         arready;
    wire  [31:0] rdata;
    wire  [1:0]  rresp;
    wire         rvalid;
    wire         serial;
    wire         led;
    wire         timer_irq;

    // testbench model
    logic [31:0] rom_model [0:(1 << ROM_BITS) - 1];
    logic [31:0] ram_model [0:(1 << RAM_BITS) - 1];
    logic [7:0]  sent_q [$];
    int          rise_q [$];
    int          cyc;
    logic        irq_prev;
    logic        irq_model;
    logic        led_model;
    logic        snap_irq;
    logic [4:0]  snap_btn;

    // tx looped straight back into rx
    soc_periph_top dut_i (
        .cpu_clk(cpu_clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .tx(serial), .rx(serial), .buttons(buttons), .led(led), .timer_irq(timer_irq)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired, the DUT stopped answering bus requests");
        abort_run();
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // cycles counted from reset release
    always @(posedge cpu_clk) begin
        if (reset) begin
            cyc = cyc + 1;
            // pending from the cycle after the counter reaches all ones
            if (cyc % IRQ_PERIOD == 0) begin
                irq_model = 1'b1;
            end
        end
    end

    always @(negedge cpu_clk) begin
        if (timer_irq && !irq_prev) begin
            rise_q.push_back(cyc);
            check_word(cyc % IRQ_PERIOD, 0, "timer_irq rise off the timer wrap");
        end
        irq_prev = timer_irq;
    end

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input bit stall, output logic [1:0] resp);
        logic [1:0] held;
        bit         first;
        bit         done;
        @(posedge cpu_clk);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(negedge cpu_clk); while (!(awready && wready));
        @(posedge cpu_clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        bready <= stall ? 1'($urandom()) : 1'b1;
        first = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge cpu_clk);
            check_bit(bvalid, 1'b1, "bvalid held until bready");
            if (first) begin
                held = bresp;
            end else begin
                check_resp(bresp, held, "bresp stable under stall");
            end
            first = 1'b0;
            done = bready;
            if (!done) begin
                @(posedge cpu_clk);
                bready <= 1'($urandom());
            end
        end
        resp = bresp;
        @(posedge cpu_clk);
        bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic [31:0] held;
        bit          first;
        bit          done;
        @(posedge cpu_clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(negedge cpu_clk); while (!arready);
        // model state as the DUT sees it at the handshake edge
        snap_irq = irq_model;
        snap_btn = buttons;
        @(posedge cpu_clk);
        arvalid <= 1'b0;
        rready <= 1'($urandom());
        first = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge cpu_clk);
            check_bit(rvalid, 1'b1, "rvalid held until rready");
            if (first) begin
                held = rdata;
            end else begin
                check_word(rdata, held, "rdata stable under stall");
            end
            first = 1'b0;
            done = rready;
            if (!done) begin
                @(posedge cpu_clk);
                rready <= 1'($urandom());
            end
        end
        data = rdata;
        resp = rresp;
        @(posedge cpu_clk);
        rready <= 1'b0;
    endtask

    task automatic wait_irq();
        do @(negedge cpu_clk); while (!timer_irq);
        // rise monitor has logged this edge by the next posedge
        @(posedge cpu_clk);
    endtask

    task automatic clear_irq();
        logic [1:0] resp;
        bus_write(PORTS, 32'h100, 4'b0010, 1'b1, resp);
        check_resp(resp, RESP_OKAY, "irq clear");
        @(negedge cpu_clk);
        irq_model = 1'b0;
        check_bit(timer_irq, irq_model, "timer_irq after clear");
    endtask

    // push n bytes, let them loop back, then drain the receive FIFO
    task automatic uart_run(input int n, input bit stall);
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [7:0]  b;
        int          accepted;
        int          expect_rx;
        sent_q.delete();
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom());
            bus_write(UART_DATA, {24'h0, b}, 4'b0001, stall, resp);
            // one byte leaves for the shifter, the rest fill the FIFO
            check_resp(resp, i < UART_FIFO_DEPTH + 1 ? RESP_OKAY : RESP_SLVERR, "uart push");
            if (i < UART_FIFO_DEPTH + 1) begin
                sent_q.push_back(b);
            end
        end
        accepted = sent_q.size();
        repeat (accepted * FRAME_CYCLES + 2 * FRAME_CYCLES) @(posedge cpu_clk);
        expect_rx = accepted < UART_FIFO_DEPTH ? accepted : UART_FIFO_DEPTH;
        for (int i = 0; i < expect_rx; i++) begin
            bus_read(UART_DATA, rd, resp);
            check_resp(resp, RESP_OKAY, "uart data read");
            check_word(rd, {24'h0, sent_q[i]}, "looped back byte");
        end
        bus_read(UART_STATUS, rd, resp);
        check_word(rd, 32'h2, "uart status after drain");
        bus_read(UART_DATA, rd, resp);
        check_resp(resp, RESP_OKAY, "empty uart data read");
        check_word(rd, 32'h0, "empty uart data");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [1:0]  resp;
        logic [7:0]  w;
        logic [3:0]  strb;
        r = $urandom(32'h237dba2d);
        reset = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        buttons = '0;
        cyc = 0;
        irq_prev = 1'b0;
        irq_model = 1'b0;
        led_model = 1'b0;
        $readmemh("rom_init.hex", rom_model);
        repeat (4) @(posedge cpu_clk);
        reset <= 1'b1;
        @(negedge cpu_clk);
        check_bit(bvalid, 1'b0, "bvalid after reset");
        check_bit(rvalid, 1'b0, "rvalid after reset");
        check_bit(awready, 1'b0, "awready after reset");
        check_bit(wready, 1'b0, "wready after reset");
        check_bit(arready, 1'b0, "arready after reset");
        check_bit(led, 1'b0, "led after reset");
        check_bit(timer_irq, 1'b0, "timer_irq after reset");
        check_bit(serial, 1'b1, "tx idle");
        @(negedge cpu_clk);
        check_bit(awready, 1'b1, "awready one cycle after reset");
        check_bit(wready, 1'b1, "wready one cycle after reset");
        check_bit(arready, 1'b1, "arready one cycle after reset");

        // timer interrupt and its clear
        wait_irq();
        bus_read(PORTS, rd, resp);
        check_bit(rd[8], 1'b1, "port irq bit");
        clear_irq();
        wait_irq();
        check_word(rise_q.size(), 2, "number of irq rises");
        check_word(rise_q[0], IRQ_PERIOD, "first irq rise");
        check_word(rise_q[1], 2 * IRQ_PERIOD, "second irq rise");
        clear_irq();

        // led and buttons
        for (int i = 0; i < 20; i++) begin
            r = $urandom();
            led_model = r[0];
            bus_write(PORTS, r, 4'b0001, 1'b1, resp);
            check_resp(resp, RESP_OKAY, "led write");
            @(negedge cpu_clk);
            check_bit(led, led_model, "led pin");
            @(posedge cpu_clk);
            buttons <= 5'($urandom());
            bus_read(PORTS, rd, resp);
            check_resp(resp, RESP_OKAY, "port read");
            check_word(rd, {23'h0, snap_irq, 1'b0, snap_btn, 1'b0, led_model}, "port word");
        end

        // rom contents and illegal accesses
        for (int i = 0; i < (1 << ROM_BITS); i++) begin
            bus_read(ROM_BASE + 32'(i * 4), rd, resp);
            check_resp(resp, RESP_OKAY, "rom read");
            check_word(rd, rom_model[i], "rom word");
        end
        bus_write(ROM_BASE + 32'h8, $urandom(), 4'hF, 1'b1, resp);
        check_resp(resp, RESP_SLVERR, "rom write");
        bus_write(UART_STATUS, $urandom(), 4'hF, 1'b1, resp);
        check_resp(resp, RESP_SLVERR, "uart status write");
        for (int i = 0; i < 4; i++) begin
            r = {5'(2 + $urandom() % 27), 27'($urandom())};
            bus_write(r, $urandom(), 4'hF, 1'b1, resp);
            check_resp(resp, RESP_SLVERR, "unmapped write");
            bus_read(r, rd, resp);
            check_resp(resp, RESP_SLVERR, "unmapped read");
        end

        // ram fill, then random byte-lane traffic
        for (int i = 0; i < (1 << RAM_BITS); i++) begin
            w = 8'(i);
            ram_model[i] = {~w, w ^ 8'h3c, w + 8'd17, w};
            bus_write(RAM_BASE + 32'(i * 4), ram_model[i], 4'hF, 1'b1, resp);
            check_resp(resp, RESP_OKAY, "ram fill");
        end
        for (int i = 0; i < 300; i++) begin
            r = $urandom();
            w = r[7:0];
            if (r[8]) begin
                wd = $urandom();
                strb = r[15:12];
                for (int l = 0; l < 4; l++) begin
                    if (strb[l]) begin
                        ram_model[w][8*l +: 8] = wd[8*l +: 8];
                    end
                end
                bus_write(RAM_BASE + {22'h0, w, 2'b00}, wd, strb, 1'b1, resp);
                check_resp(resp, RESP_OKAY, "ram write");
            end else begin
                bus_read(RAM_BASE + {22'h0, w, 2'b00}, rd, resp);
                check_resp(resp, RESP_OKAY, "ram read");
                check_word(rd, ram_model[w], "ram word");
            end
        end

        // uart loopback, then an overflow burst
        uart_run(3, 1'b1);
        uart_run(UART_FIFO_DEPTH + 2, 1'b0);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart/uart_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module uart_fifo import soc_pkg::*; (
    input  logic       cpu_clk,
    input  logic       reset,
    input  logic       uart_push,
    input  logic [7:0] wr_data,
    input  logic       uart_pop,
    input  logic       rx,
    output logic       tx,
    output logic [7:0] uart_rdata,
    output logic       uart_full,
    output logic       uart_empty
);
    logic [7:0]               tx_mem [0:UART_FIFO_DEPTH-1];
    logic [UART_PTR_BITS:0]   tx_wr_ptr;
    logic [UART_PTR_BITS:0]   tx_rd_ptr;
    logic                     tx_empty;
    logic                     tx_load;
    logic                     tx_busy;
    logic [9:0]               tx_shift;
    logic [UART_DIV_BITS-1:0] tx_div;
    logic [3:0]               tx_bit;

    logic [7:0]               rx_mem [0:UART_FIFO_DEPTH-1];
    logic [UART_PTR_BITS:0]   rx_wr_ptr;
    logic [UART_PTR_BITS:0]   rx_rd_ptr;
    logic                     rx_full;
    logic                     rx_s1;
    logic                     rx_s2;
    logic                     rx_busy;
    logic                     rx_mid;
    logic                     rx_push;
    logic [7:0]               rx_shift;
    logic [UART_DIV_BITS-1:0] rx_div;
    logic [3:0]               rx_bit;

    // full when pointers differ only in the wrap bit
    assign uart_full = (tx_wr_ptr ^ tx_rd_ptr) == {1'b1, {UART_PTR_BITS{1'b0}}};
    assign tx_empty = tx_wr_ptr == tx_rd_ptr;
    assign rx_full = (rx_wr_ptr ^ rx_rd_ptr) == {1'b1, {UART_PTR_BITS{1'b0}}};
    assign uart_empty = rx_wr_ptr == rx_rd_ptr;

    assign tx_load = !tx_busy && !tx_empty;
    assign tx = tx_shift[0];

    always_ff @(posedge cpu_clk) begin
        if (uart_push) begin
            tx_mem[tx_wr_ptr[UART_PTR_BITS-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            tx_wr_ptr <= '0;
            tx_rd_ptr <= '0;
            tx_busy <= 1'b0;
            tx_shift <= '1;
            tx_div <= '0;
            tx_bit <= '0;
        end else begin
            if (uart_push) begin
                tx_wr_ptr <= tx_wr_ptr + 1'b1;
            end
            if (tx_load) begin
                // stop, data lsb first, start
                tx_shift <= {1'b1, tx_mem[tx_rd_ptr[UART_PTR_BITS-1:0]], 1'b0};
                tx_rd_ptr <= tx_rd_ptr + 1'b1;
                tx_busy <= 1'b1;
                tx_div <= '0;
                tx_bit <= '0;
            end else if (tx_busy) begin
                if (tx_div == UART_DIV_BITS'(UART_CLOCK_DIV - 1)) begin
                    tx_div <= '0;
                    tx_shift <= {1'b1, tx_shift[9:1]};
                    tx_bit <= tx_bit + 1'b1;
                    if (tx_bit == 4'd9) begin
                        tx_busy <= 1'b0;
                    end
                end else begin
                    tx_div <= tx_div + 1'b1;
                end
            end
        end
    end

    // sample points sit half a bit after each boundary
    assign rx_mid = rx_busy && rx_div == UART_DIV_BITS'(UART_CLOCK_DIV / 2);
    assign rx_push = rx_mid && rx_bit == 4'd9 && rx_s2 && !rx_full;

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_busy <= 1'b0;
            rx_div <= '0;
            rx_bit <= '0;
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            if (uart_pop && !uart_empty) begin
                rx_rd_ptr <= rx_rd_ptr + 1'b1;
            end
            if (rx_push) begin
                rx_wr_ptr <= rx_wr_ptr + 1'b1;
            end
            if (!rx_busy) begin
                if (!rx_s2) begin
                    rx_busy <= 1'b1;
                    rx_div <= '0;
                    rx_bit <= '0;
                end
            end else begin
                if (rx_div == UART_DIV_BITS'(UART_CLOCK_DIV - 1)) begin
                    rx_div <= '0;
                    rx_bit <= rx_bit + 1'b1;
                end else begin
                    rx_div <= rx_div + 1'b1;
                end
                // false start or end of frame
                if (rx_mid && ((rx_bit == 4'd0 && rx_s2) || rx_bit == 4'd9)) begin
                    rx_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (rx_mid && rx_bit inside {[4'd1:4'd8]}) begin
            rx_shift <= {rx_s2, rx_shift[7:1]};
        end
        if (rx_push) begin
            rx_mem[rx_wr_ptr[UART_PTR_BITS-1:0]] <= rx_shift;
        end
        if (uart_pop) begin
            uart_rdata <= uart_empty ? 8'h00 : rx_mem[rx_rd_ptr[UART_PTR_BITS-1:0]];
        end
    end

    // the bus front end answers SLVERR instead of pushing
    a_no_push_full: assert property (@(posedge cpu_clk) disable iff (!reset)
        uart_push |-> !uart_full);

endmodule

`default_nettype wire
